//--- Bender.yml
package:
  name: fletcherApb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fletcherPkg.sv
      - hdl/apbRegs.sv
      - hdl/fletcherEngine.sv
      - hdl/resultCheck.sv
      - hdl/fletcherApb.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/fletcherApb_props.sv
      - test/fletcherTb.sv

//--- fletcherApb.f
+incdir+hdl
hdl/fletcherPkg.sv
hdl/apbRegs.sv
hdl/fletcherEngine.sv
hdl/resultCheck.sv
hdl/fletcherApb.sv
test/fletcherApb_props.sv
test/fletcherTb.sv

//--- hdl/apbRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_config.svh"

module apbRegs (
    input  wire                          clk,
    input  wire                          rst,
    input  wire fletcherPkg::apbReq      req,
    input  wire fletcherPkg::sumOut      sums,
    input  wire [31:0]                   status,
    output fletcherPkg::apbResp          resp,
    output fletcherPkg::wordIn           word,
    output logic [`FLETCHER_WIDTH-1:0]   expected
);
    import fletcherPkg::*;

    logic                       access;
    logic                       addrOk;
    logic                       writeOk;
    logic                       resultRead;
    logic                       stall;
    logic                       done;
    logic                       bad;
    logic                       goodWrite;
    logic [31:0]                readMux;
    logic [`FLETCHER_WIDTH-1:0] expectReg;
    logic                       validQ;
    logic                       clearQ;
    logic [`FLETCHER_HALF-1:0]  dataQ;

    assign access = req.psel & req.penable;

    // address decode and read data
    always_comb begin
        addrOk = 1'b1;
        writeOk = 1'b1;
        resultRead = 1'b0;
        readMux = '0;
        case (req.paddr)
            CtrlReg, DataReg: begin
                readMux = '0;    // write only, read as zero
            end
            SumReg: begin
                readMux = {sums.b, sums.a};
                writeOk = 1'b0;
                resultRead = 1'b1;
            end
            ExpectReg: begin
                readMux = expectReg;
            end
            StatusReg: begin
                readMux = status;
                writeOk = 1'b0;
                resultRead = 1'b1;
            end
            default: begin
                addrOk = 1'b0;
            end
        endcase
    end

    // result reads wait until every word is folded into b
    assign stall = access & ~req.pwrite & resultRead & sums.busy;
    assign done = access & ~stall;
    assign bad = ~addrOk | (req.pwrite & ~writeOk);
    assign goodWrite = done & req.pwrite & ~bad;

    always_comb begin
        resp.pready = ~stall;
        resp.pslverr = done & bad;
        resp.prdata = (done & ~req.pwrite & ~bad) ? readMux : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
            clearQ <= 1'b0;
            expectReg <= '0;
        end else begin
            clearQ <= goodWrite & (req.paddr == CtrlReg) & req.pwdata[0];
            validQ <= goodWrite & (req.paddr == DataReg);
            if (goodWrite && req.paddr == ExpectReg) begin
                expectReg <= req.pwdata;
            end
        end
    end

    // word payload, only meaningful with validQ
    always_ff @(posedge clk) begin
        if (goodWrite && req.paddr == DataReg) begin
            dataQ <= req.pwdata[`FLETCHER_HALF-1:0];
        end
    end

    assign word = '{valid: validQ, clear: clearQ, data: dataQ};
    assign expected = expectReg;

endmodule

`default_nettype wire

//--- hdl/fletcherApb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_config.svh"

module fletcherApb (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0]  paddr,
    input  wire [31:0]                 pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import fletcherPkg::*;

    apbReq                      req;
    apbResp                     resp;
    wordIn                      word;
    sumOut                      sums;
    logic [31:0]                status;
    logic [`FLETCHER_WIDTH-1:0] expected;

    assign req = '{psel: psel, penable: penable, pwrite: pwrite, paddr: paddr, pwdata: pwdata};

    assign prdata = resp.prdata;
    assign pready = resp.pready;
    assign pslverr = resp.pslverr;

    apbRegs regs (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .sums     (sums),
        .status   (status),
        .resp     (resp),
        .word     (word),
        .expected (expected)
    );

    fletcherEngine engine (
        .clk  (clk),
        .rst  (rst),
        .word (word),
        .sums (sums)
    );

    resultCheck check (
        .clk      (clk),
        .rst      (rst),
        .word     (word),
        .sums     (sums),
        .expected (expected),
        .status   (status)
    );

endmodule

`default_nettype wire

//--- hdl/fletcherEngine.sv
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_config.svh"

module fletcherEngine (
    input  wire                      clk,
    input  wire                      rst,
    input  wire fletcherPkg::wordIn  word,
    output fletcherPkg::sumOut       sums
);
    logic [`FLETCHER_HALF-1:0] sumA;
    logic [`FLETCHER_HALF-1:0] sumB;
    logic                      stageValid;    // sumA holds a word not yet in sumB

    // mod 65535 add, all-ones folds to zero
    function automatic logic [`FLETCHER_HALF-1:0] onesAdd(
        input logic [`FLETCHER_HALF-1:0] x,
        input logic [`FLETCHER_HALF-1:0] y
    );
        logic [`FLETCHER_HALF:0]   raw;
        logic [`FLETCHER_HALF-1:0] wrapped;
        raw = {1'b0, x} + {1'b0, y};
        wrapped = raw[`FLETCHER_HALF-1:0] + raw[`FLETCHER_HALF];    // end-around carry
        return (&wrapped) ? '0 : wrapped;
    endfunction

    // stage one, word into A
    always_ff @(posedge clk) begin
        if (rst || word.clear) begin
            sumA <= '0;
            stageValid <= 1'b0;
        end else begin
            stageValid <= word.valid;
            if (word.valid) begin
                sumA <= onesAdd(sumA, word.data);
            end
        end
    end

    // stage two, the new A into B
    always_ff @(posedge clk) begin
        if (rst || word.clear) begin
            sumB <= '0;
        end else if (stageValid) begin
            sumB <= onesAdd(sumB, sumA);
        end
    end

    // up to two words in flight
    assign sums = '{a: sumA, b: sumB, busy: word.valid | stageValid};

endmodule

`default_nettype wire

//--- hdl/fletcherPkg.sv
`default_nettype none

`include "fletcher_config.svh"

package fletcherPkg;

    // host side of the APB port
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } apbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbResp;

    // register map, also used as the command decode
    typedef enum logic [`APB_ADDR_WIDTH-1:0] {
        CtrlReg   = 8'h00,    // bit 0 clears
        DataReg   = 8'h04,    // low 16 bits are one word
        SumReg    = 8'h08,
        ExpectReg = 8'h0C,
        StatusReg = 8'h10
    } regAddr;

    typedef struct packed {
        logic                      valid;
        logic                      clear;    // wins over valid
        logic [`FLETCHER_HALF-1:0] data;
    } wordIn;

    typedef struct packed {
        logic [`FLETCHER_HALF-1:0] a;
        logic [`FLETCHER_HALF-1:0] b;
        logic                      busy;    // a word not yet folded into b
    } sumOut;

endpackage

`default_nettype wire

//--- hdl/fletcher_config.svh
`ifndef FLETCHER_CONFIG_SVH
`define FLETCHER_CONFIG_SVH

// full checksum, B in the upper half and A in the lower half
`define FLETCHER_WIDTH 32

// input word and each running sum
`define FLETCHER_HALF 16

// APB byte offset width
`define APB_ADDR_WIDTH 8

// words since last clear, wraps
`define COUNT_WIDTH 16

`endif

//--- hdl/resultCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_config.svh"

module resultCheck (
    input  wire                          clk,
    input  wire                          rst,
    input  wire fletcherPkg::wordIn      word,
    input  wire fletcherPkg::sumOut      sums,
    input  wire [`FLETCHER_WIDTH-1:0]    expected,
    output logic [31:0]                  status
);
    logic [`COUNT_WIDTH-1:0] count;
    logic                    match;

    // words accepted since the last clear
    always_ff @(posedge clk) begin
        if (rst || word.clear) begin
            count <= '0;
        end else if (word.valid) begin
            count <= count + 1'b1;    // wraps at 2**16
        end
    end

    assign match = ({sums.b, sums.a} == expected);

    // count on top, flags at the bottom
    assign status = {count, {(32 - `COUNT_WIDTH - 2){1'b0}}, sums.busy, match};

endmodule

`default_nettype wire

//--- test/fletcherApb_props.sv
`timescale 1ns/1ps
`default_nettype none

module fletcherApbProps (
    input wire                     clk,
    input wire                     rst,
    input wire                     psel,
    input wire                     penable,
    input wire                     pready,
    input wire                     pslverr,
    input wire fletcherPkg::wordIn word,
    input wire fletcherPkg::sumOut sums
);

    // access phase only right after a setup cycle
    assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel) && psel)
        else $error("penable rose without a setup cycle");

    // host holds the access phase through wait states
    assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pready) |=> (psel && penable))
        else $error("access phase dropped during a wait state");

    assert property (@(posedge clk) disable iff (rst)
        pslverr |-> pready)
        else $error("pslverr raised without pready");

    // 65535 always folds to zero
    assert property (@(posedge clk) disable iff (rst)
        (sums.a != 16'hFFFF) && (sums.b != 16'hFFFF))
        else $error("a running sum holds 0xFFFF");

    assert property (@(posedge clk) disable iff (rst)
        (word.valid ##1 !word.valid [*2]) |-> !sums.busy)
        else $error("busy still high 2 cycles after the last word");

endmodule

bind fletcherApb fletcherApbProps props (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .word    (word),
    .sums    (sums)
);

`default_nettype wire

//--- test/fletcherTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_config.svh"

module fletcherTb;
    import fletcherPkg::*;

    localparam int stimLen = 25;
    localparam int timeoutCycles = stimLen * 40;
    localparam int stallLimit = 16;    // cycles a read may wait on pready
    localparam logic [31:0] seed = 32'hb7666303;

    typedef enum logic [2:0] {
        CmdWords,
        CmdRandom,
        CmdRead,
        CmdClear,
        CmdExpect,
        CmdBad
    } stimCmd;

    typedef struct packed {
        stimCmd           cmd;
        logic [7:0]       count;       // 0 with CmdRandom picks 1 to 20 words
        logic [0:3][15:0] words;       // used in turn, then repeated
        logic             hasFixed;
        logic [31:0]      fixed;       // known checksum
    } stimEntry;

    logic                       clk;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;

    stimEntry    stim [stimLen];
    int          errors;
    int          checks;
    int          cycleCount;
    logic [31:0] lcgState;
    logic [31:0] mA;    // reference sums, always below 65535
    logic [31:0] mB;
    logic [15:0] mCount;
    logic [31:0] mExpect;

    fletcherApb uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("run stopped after %0d cycles, the stimulus never finished", cycleCount);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEqual(input string name, input logic [31:0] want, input logic [31:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, want, got);
        end
    endtask

    // one APB transfer, called 1 ns after a rising edge
    task automatic apbAccess(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int waitCycles;
        waitCycles = 0;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        if (write || (addr != SumReg && addr != StatusReg)) begin
            checkEqual("pready (zero wait states)", 32'd1, pready);    // only result reads stall
        end
        while (!pready && waitCycles < stallLimit) begin
            waitCycles++;
            @(negedge clk);
        end
        if (!pready) begin
            errors++;
            $display("pready never returned on access to 0x%02h at %0t ns", addr, $time);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // Fletcher-32 rule, A first and then B with the new A
    task automatic modelWord(input logic [15:0] d);
        mA = (mA + d) % 32'd65535;
        mB = (mB + mA) % 32'd65535;
        mCount = mCount + 1'b1;
    endtask

    task automatic writeWord(input logic [15:0] d);
        logic [31:0] rdata;
        logic        err;
        apbAccess(1'b1, DataReg, {16'h0000, d}, rdata, err);
        checkEqual("pslverr (DataReg write)", 32'd0, err);
        modelWord(d);
    endtask

    task automatic checkAll(input logic hasFixed, input logic [31:0] fixed);
        logic [31:0] rdata;
        logic [31:0] want;
        logic        err;
        want = {mB[15:0], mA[15:0]};
        apbAccess(1'b0, SumReg, 32'h0, rdata, err);
        checkEqual("pslverr (SumReg read)", 32'd0, err);
        checkEqual("prdata (SumReg)", want, rdata);
        if (hasFixed) begin
            checkEqual("prdata (SumReg, known vector)", fixed, rdata);
        end
        if (rdata[15:0] == 16'hFFFF || rdata[31:16] == 16'hFFFF) begin
            errors++;
            $display("a sum read back as 0xFFFF instead of zero at %0t ns", $time);
        end
        apbAccess(1'b0, StatusReg, 32'h0, rdata, err);
        checkEqual("pslverr (StatusReg read)", 32'd0, err);
        checkEqual("prdata (StatusReg)", {mCount, 14'h0, 1'b0, want == mExpect}, rdata);
        apbAccess(1'b0, ExpectReg, 32'h0, rdata, err);
        checkEqual("pslverr (ExpectReg read)", 32'd0, err);
        checkEqual("prdata (ExpectReg)", mExpect, rdata);
    endtask

    task automatic applyEntry(input stimEntry e);
        int          n;
        logic [31:0] rdata;
        logic [31:0] sum;
        logic        err;
        case (e.cmd)
            CmdWords: begin
                for (int i = 0; i < e.count; i++) begin
                    writeWord(e.words[i % 4]);
                end
            end
            CmdRandom: begin
                n = e.count;
                if (n == 0) begin
                    lcgState = lcgStep(lcgState);
                    n = lcgState[31:16] % 20 + 1;
                end
                for (int i = 0; i < n; i++) begin
                    lcgState = lcgStep(lcgState);
                    writeWord(lcgState[31:16]);
                end
            end
            CmdRead: begin
                checkAll(e.hasFixed, e.fixed);
            end
            CmdClear: begin
                apbAccess(1'b1, CtrlReg, 32'h1, rdata, err);
                checkEqual("pslverr (CtrlReg write)", 32'd0, err);
                mA = 0;
                mB = 0;
                mCount = 0;
                checkAll(1'b1, 32'h0);
            end
            CmdExpect: begin
                sum = {mB[15:0], mA[15:0]};
                apbAccess(1'b1, ExpectReg, sum, rdata, err);
                checkEqual("pslverr (ExpectReg write)", 32'd0, err);
                mExpect = sum;
                checkAll(1'b0, 32'h0);
                lcgState = lcgStep(lcgState);
                mExpect = sum ^ (32'h1 << lcgState[20:16]);    // one bit off
                apbAccess(1'b1, ExpectReg, mExpect, rdata, err);
                checkEqual("pslverr (ExpectReg write)", 32'd0, err);
                checkAll(1'b0, 32'h0);
            end
            CmdBad: begin
                apbAccess(1'b0, 8'h14, 32'h0, rdata, err);
                checkEqual("pslverr (read of 0x14)", 32'd1, err);
                checkEqual("prdata (read of 0x14)", 32'h0, rdata);
                apbAccess(1'b1, SumReg, 32'hdeadbeef, rdata, err);
                checkEqual("pslverr (SumReg write)", 32'd1, err);
                apbAccess(1'b1, StatusReg, 32'hffffffff, rdata, err);
                checkEqual("pslverr (StatusReg write)", 32'd1, err);
                checkAll(1'b0, 32'h0);
            end
            default: begin
                errors++;
                $display("unknown stimulus command in the table");
            end
        endcase
    endtask

    initial begin
        errors = 0;
        checks = 0;
        cycleCount = 0;
        lcgState = seed;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mA = 0;
        mB = 0;
        mCount = 0;
        mExpect = 0;

        stim[0] = '{CmdRead, 8'd0, 64'h0, 1'b1, 32'h0};    // reset values
        stim[1] = '{CmdWords, 8'd3, {16'h6261, 16'h6463, 16'h0065, 16'h0}, 1'b0, 32'h0};
        stim[2] = '{CmdRead, 8'd0, 64'h0, 1'b1, 32'hF04FC729};
        stim[3] = '{CmdClear, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[4] = '{CmdWords, 8'd3, {16'h6261, 16'h6463, 16'h6665, 16'h0}, 1'b0, 32'h0};
        stim[5] = '{CmdRead, 8'd0, 64'h0, 1'b1, 32'h56502D2A};
        stim[6] = '{CmdExpect, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[7] = '{CmdClear, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[8] = '{CmdRandom, 8'd1, 64'h0, 1'b0, 32'h0};
        stim[9] = '{CmdRead, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[10] = '{CmdRandom, 8'd20, 64'h0, 1'b0, 32'h0};
        stim[11] = '{CmdRead, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[12] = '{CmdRandom, 8'd7, 64'h0, 1'b0, 32'h0};
        stim[13] = '{CmdExpect, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[14] = '{CmdClear, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[15] = '{CmdWords, 8'd12, {4{16'hFFFF}}, 1'b0, 32'h0};
        stim[16] = '{CmdRead, 8'd0, 64'h0, 1'b1, 32'h0};    // all-ones words add nothing
        stim[17] = '{CmdWords, 8'd10, {16'hFFFE, 16'hFFFF, 16'hFFFE, 16'hFFFE}, 1'b0, 32'h0};
        stim[18] = '{CmdRead, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[19] = '{CmdBad, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[20] = '{CmdRandom, 8'd13, 64'h0, 1'b0, 32'h0};
        stim[21] = '{CmdRead, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[22] = '{CmdClear, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[23] = '{CmdRandom, 8'd0, 64'h0, 1'b0, 32'h0};
        stim[24] = '{CmdRead, 8'd0, 64'h0, 1'b0, 32'h0};

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < stimLen; i++) begin
            applyEntry(stim[i]);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
